// File: robPkg.sv
package robPkg;

  // Buffer geometry
  localparam int RobIdLen = 6;
  localparam int RobLength = 1 << RobIdLen;
  localparam int DecWidth = 4;
  localparam int LaneBits = $clog2(DecWidth);
  localparam int BankDepth = RobLength / DecWidth;
  localparam int BankIdLen = RobIdLen - LaneBits;
  localparam int NumCompPorts = 3;

  // Index plus one wrap bit so a full window differs from an empty one
  typedef logic [RobIdLen:0] sqN_t;

  // Physical tag and architectural register
  typedef logic [6:0] tag_t;
  typedef logic [4:0] regNm_t;

  // Cause of a trap detected at decode
  typedef logic [4:0] trapCode_t;

  // Tag that stands for x0 whose results are dropped
  localparam tag_t TagZero = 7'h40;

  // Completion state of an entry
  typedef logic [2:0] robFlags_t;

  localparam robFlags_t NotExecuted = 3'd0;
  localparam robFlags_t None = 3'd1;
  localparam robFlags_t Branch = 3'd2;
  localparam robFlags_t Trap = 3'd3;
  localparam robFlags_t Exception = 3'd4;

  // How rename classifies an op at enqueue
  localparam int KindBits = 2;

  localparam logic [KindBits-1:0] KindExecute = 2'd0;
  localparam logic [KindBits-1:0] KindRename = 2'd1;
  localparam logic [KindBits-1:0] KindTrap = 2'd2;

  // Destination word, holds a trap cause when the flags say Trap
  typedef union packed {
    regNm_t rd;
    trapCode_t code;
  } robDest_u;

  // Stored part of an entry without the flags which live in their own table
  typedef struct packed {
    tag_t tag;
    robDest_u dest;
  } robEntry_t;

endpackage

// File: robEntryBanks.sv
`timescale 1ns/1ns

module robEntryBanks (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             enqValid [robPkg::DecWidth],
  input  robPkg::sqN_t                     enqSqN   [robPkg::DecWidth],
  input  robPkg::robEntry_t                enqEntry [robPkg::DecWidth],
  input  logic                             brTaken,
  input  logic [robPkg::RobIdLen-1:0]      rdIdx    [robPkg::DecWidth],
  output robPkg::robEntry_t                rdEntry  [robPkg::DecWidth]
);
  import robPkg::*;

  // One bank per lane, selected by the low bits of the sequence number
  robEntry_t bankMem [DecWidth][BankDepth];

  logic wrValid [DecWidth];
  logic [BankIdLen-1:0] wrRow [DecWidth];
  robEntry_t wrEntry [DecWidth];

  logic [BankIdLen-1:0] rdRow [DecWidth];
  robEntry_t bankOut [DecWidth];

  // Sort rename lanes into bank order
  always_comb begin
    for (int b = 0; b < DecWidth; b++) begin
      wrValid[b] = 1'b0;
      wrRow[b] = '0;
      wrEntry[b] = '0;
      for (int j = 0; j < DecWidth; j++) begin
        // Consecutive sequence numbers never put two lanes in one bank
        if (enqValid[j] && enqSqN[j][LaneBits-1:0] == LaneBits'(b)) begin
          wrValid[b] = 1'b1;
          wrRow[b] = enqSqN[j][RobIdLen-1:LaneBits];
          wrEntry[b] = enqEntry[j];
        end
      end
    end
  end

  // Ops renamed in the cycle of a taken branch are younger than it
  always_ff @(posedge clk) begin
    for (int b = 0; b < DecWidth; b++) begin
      if (wrValid[b] && !brTaken && !rst) begin
        bankMem[b][wrRow[b]] <= wrEntry[b];
      end
    end
  end

  // Commit window is four consecutive indices, so each bank sees one read
  always_comb begin
    for (int b = 0; b < DecWidth; b++) begin
      rdRow[b] = '0;
    end
    for (int i = 0; i < DecWidth; i++) begin
      rdRow[rdIdx[i][LaneBits-1:0]] = rdIdx[i][RobIdLen-1:LaneBits];
    end
  end

  always_comb begin
    for (int b = 0; b < DecWidth; b++) begin
      bankOut[b] = bankMem[b][rdRow[b]];
    end
    // Rotate back into commit order
    for (int i = 0; i < DecWidth; i++) begin
      rdEntry[i] = bankOut[rdIdx[i][LaneBits-1:0]];
    end
  end

endmodule

// File: robFlagTable.sv
`timescale 1ns/1ns

module robFlagTable (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enqValid  [robPkg::DecWidth],
  input  robPkg::sqN_t                enqSqN    [robPkg::DecWidth],
  input  robPkg::robFlags_t           enqFlags  [robPkg::DecWidth],
  input  logic                        compValid [robPkg::NumCompPorts],
  input  robPkg::sqN_t                compSqN   [robPkg::NumCompPorts],
  input  robPkg::robFlags_t           compFlags [robPkg::NumCompPorts],
  input  logic                        brTaken,
  input  robPkg::sqN_t                brSqN,
  input  logic [robPkg::RobIdLen-1:0] rdIdx     [robPkg::DecWidth],
  output robPkg::robFlags_t           rdFlags   [robPkg::DecWidth]
);
  import robPkg::*;

  robFlags_t flagMem [RobLength];
  logic compKeep [NumCompPorts];

  // Results of ops younger than a taken branch are from the wrong path
  always_comb begin
    for (int p = 0; p < NumCompPorts; p++) begin
      compKeep[p] = compValid[p] &&
                    (!brTaken || $signed(compSqN[p] - brSqN) <= 0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < RobLength; k++) begin
        flagMem[k] <= NotExecuted;
      end
    end else begin
      // Initial state from rename
      if (!brTaken) begin
        for (int i = 0; i < DecWidth; i++) begin
          if (enqValid[i]) begin
            flagMem[enqSqN[i][RobIdLen-1:0]] <= enqFlags[i];
          end
        end
      end
      // Out-of-order completion from the execution units
      for (int p = 0; p < NumCompPorts; p++) begin
        if (compKeep[p]) begin
          flagMem[compSqN[p][RobIdLen-1:0]] <= compFlags[p];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DecWidth; i++) begin
      rdFlags[i] = flagMem[rdIdx[i]];
    end
  end

endmodule

// File: robWindow.sv
`timescale 1ns/1ns

module robWindow (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enqValid [robPkg::DecWidth],
  input  robPkg::sqN_t                enqSqN   [robPkg::DecWidth],
  input  logic                        brTaken,
  input  robPkg::sqN_t                brSqN,
  input  logic [robPkg::LaneBits:0]   comCount,
  output robPkg::sqN_t                baseSqN,
  output robPkg::sqN_t                lastSqN,
  output logic [robPkg::RobIdLen-1:0] rdIdx    [robPkg::DecWidth],
  output robPkg::sqN_t                maxSqN
);
  import robPkg::*;

  // Base is the oldest live op, last is one past the youngest
  always_ff @(posedge clk) begin
    if (rst) begin
      baseSqN <= '0;
      lastSqN <= '0;
    end else begin
      baseSqN <= baseSqN + sqN_t'(comCount);

      if (brTaken) begin
        // Everything after the branch is discarded
        lastSqN <= brSqN + sqN_t'(1);
      end else begin
        // Lanes come in age order so the highest valid lane is the youngest
        for (int i = 0; i < DecWidth; i++) begin
          if (enqValid[i]) begin
            lastSqN <= enqSqN[i] + sqN_t'(1);
          end
        end
      end
    end
  end

  // Candidate commit slots for this cycle
  always_comb begin
    for (int i = 0; i < DecWidth; i++) begin
      rdIdx[i] = baseSqN[RobIdLen-1:0] + RobIdLen'(i);
    end
  end

  // Youngest sequence number rename may allocate
  assign maxSqN = baseSqN + sqN_t'(RobLength - 1);

endmodule

// File: robCommit.sv
`timescale 1ns/1ns

module robCommit (
  input  logic                      clk,
  input  logic                      rst,
  input  robPkg::sqN_t              baseSqN,
  input  robPkg::sqN_t              lastSqN,
  input  robPkg::robEntry_t         rdEntry  [robPkg::DecWidth],
  input  robPkg::robFlags_t         rdFlags  [robPkg::DecWidth],
  output logic [robPkg::LaneBits:0] comCount,
  output logic                      comValid [robPkg::DecWidth],
  output robPkg::sqN_t              comSqN   [robPkg::DecWidth],
  output robPkg::regNm_t            comRd    [robPkg::DecWidth],
  output robPkg::tag_t              comTag   [robPkg::DecWidth],
  output logic                      trapValid,
  output robPkg::sqN_t              trapSqN,
  output robPkg::tag_t              trapTag,
  output robPkg::robDest_u          trapDest,
  output robPkg::robFlags_t         trapFlags,
  output robPkg::sqN_t              curSqN
);
  import robPkg::*;

  // Set for one cycle after a trap to hold commit while the core redirects
  logic stopReg;

  sqN_t fill;
  logic inGroup;
  logic laneCommit [DecWidth];
  logic laneTrap [DecWidth];
  logic anyTrap;
  logic [LaneBits-1:0] trapLane;

  // Count of renamed ops in the window from 0 to RobLength
  assign fill = lastSqN - baseSqN;

  // Longest in-order prefix of executed ops
  always_comb begin
    inGroup = !stopReg;
    comCount = '0;
    anyTrap = 1'b0;
    trapLane = '0;
    for (int i = 0; i < DecWidth; i++) begin
      laneCommit[i] = 1'b0;
      laneTrap[i] = 1'b0;
      if (inGroup && sqN_t'(i) < fill && rdFlags[i] != NotExecuted) begin
        // Branch and None both retire normally
        laneCommit[i] = 1'b1;
        comCount = comCount + 1'b1;
        if (rdFlags[i] == Trap || rdFlags[i] == Exception) begin
          laneTrap[i] = 1'b1;
          anyTrap = 1'b1;
          trapLane = LaneBits'(i);
          inGroup = 1'b0;
        end
      end else begin
        inGroup = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stopReg <= 1'b0;
      for (int i = 0; i < DecWidth; i++) begin
        comValid[i] <= 1'b0;
      end
    end else begin
      stopReg <= anyTrap;
      for (int i = 0; i < DecWidth; i++) begin
        comValid[i] <= laneCommit[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DecWidth; i++) begin
      comSqN[i] <= baseSqN + sqN_t'(i);
      if (laneTrap[i]) begin
        // Trapping op writes nothing to the register file
        comRd[i] <= '0;
        comTag[i] <= TagZero;
      end else begin
        comRd[i] <= rdEntry[i].dest.rd;
        comTag[i] <= rdEntry[i].tag;
      end
    end
    if (anyTrap) begin
      trapSqN <= baseSqN + sqN_t'(trapLane);
      trapTag <= rdEntry[trapLane].tag;
      // Trap code of a decode trap or register of an exception
      trapDest <= rdEntry[trapLane].dest;
      trapFlags <= rdFlags[trapLane];
    end
  end

  // The stop bit is exactly the cycle the trap record is valid
  assign trapValid = stopReg;
  assign curSqN = baseSqN;

endmodule

// File: reorderBuffer.sv
`timescale 1ns/1ns

module reorderBuffer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enqValid  [robPkg::DecWidth],
  input  robPkg::sqN_t                enqSqN    [robPkg::DecWidth],
  input  robPkg::tag_t                enqTag    [robPkg::DecWidth],
  input  robPkg::robDest_u            enqDest   [robPkg::DecWidth],
  input  logic [robPkg::KindBits-1:0] enqKind   [robPkg::DecWidth],
  input  logic                        compValid [robPkg::NumCompPorts],
  input  robPkg::sqN_t                compSqN   [robPkg::NumCompPorts],
  input  robPkg::robFlags_t           compFlags [robPkg::NumCompPorts],
  input  logic                        brTaken,
  input  robPkg::sqN_t                brSqN,
  output logic                        comValid  [robPkg::DecWidth],
  output robPkg::sqN_t                comSqN    [robPkg::DecWidth],
  output robPkg::regNm_t              comRd     [robPkg::DecWidth],
  output robPkg::tag_t                comTag    [robPkg::DecWidth],
  output logic                        trapValid,
  output robPkg::sqN_t                trapSqN,
  output robPkg::tag_t                trapTag,
  output robPkg::robDest_u            trapDest,
  output robPkg::robFlags_t           trapFlags,
  output robPkg::sqN_t                curSqN,
  output robPkg::sqN_t                maxSqN
);
  import robPkg::*;

  robEntry_t enqEntry [DecWidth];
  robFlags_t enqFlags [DecWidth];
  logic [RobIdLen-1:0] rdIdx [DecWidth];
  robEntry_t rdEntry [DecWidth];
  robFlags_t rdFlags [DecWidth];
  sqN_t baseSqN;
  sqN_t lastSqN;
  logic [LaneBits:0] comCount;

  // Split each rename lane into its stored entry and initial flags
  always_comb begin
    for (int i = 0; i < DecWidth; i++) begin
      enqEntry[i] = {enqTag[i], enqDest[i]};
      case (enqKind[i])
        KindRename:  enqFlags[i] = None;
        KindTrap:    enqFlags[i] = Trap;
        KindExecute: enqFlags[i] = NotExecuted;
        default:     enqFlags[i] = NotExecuted;
      endcase
    end
  end

  robEntryBanks entryBanks (
    .clk(clk), .rst(rst),
    .enqValid(enqValid), .enqSqN(enqSqN), .enqEntry(enqEntry),
    .brTaken(brTaken), .rdIdx(rdIdx), .rdEntry(rdEntry)
  );

  robFlagTable flagTable (
    .clk(clk), .rst(rst),
    .enqValid(enqValid), .enqSqN(enqSqN), .enqFlags(enqFlags),
    .compValid(compValid), .compSqN(compSqN), .compFlags(compFlags),
    .brTaken(brTaken), .brSqN(brSqN), .rdIdx(rdIdx), .rdFlags(rdFlags)
  );

  robWindow window (
    .clk(clk), .rst(rst),
    .enqValid(enqValid), .enqSqN(enqSqN), .brTaken(brTaken), .brSqN(brSqN),
    .comCount(comCount), .baseSqN(baseSqN), .lastSqN(lastSqN),
    .rdIdx(rdIdx), .maxSqN(maxSqN)
  );

  robCommit commit (
    .clk(clk), .rst(rst),
    .baseSqN(baseSqN), .lastSqN(lastSqN), .rdEntry(rdEntry), .rdFlags(rdFlags),
    .comCount(comCount), .comValid(comValid), .comSqN(comSqN),
    .comRd(comRd), .comTag(comTag),
    .trapValid(trapValid), .trapSqN(trapSqN), .trapTag(trapTag),
    .trapDest(trapDest), .trapFlags(trapFlags), .curSqN(curSqN)
  );

endmodule

// File: reorderBuffer_props.sv
`timescale 1ns/1ns

module reorderBufferProps (
  input logic         clk,
  input logic         rst,
  input logic         comValid [robPkg::DecWidth],
  input robPkg::sqN_t comSqN   [robPkg::DecWidth],
  input logic         trapValid,
  input robPkg::sqN_t curSqN,
  input robPkg::sqN_t maxSqN
);
  import robPkg::*;

  logic anyCommit;

  always_comb begin
    anyCommit = 1'b0;
    for (int i = 0; i < DecWidth; i++) begin
      anyCommit = anyCommit | comValid[i];
    end
  end

  // Commit is blocked for the cycle that follows a trap record
  assert property (@(posedge clk) disable iff (rst) trapValid |=> !anyCommit)
    else $error("commit in the cycle after a trap record");

  // Committed lanes form a prefix with consecutive sequence numbers
  for (genvar i = 1; i < DecWidth; i++) begin : laneOrder
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] |-> comValid[i-1] && comSqN[i] == comSqN[i-1] + 1'b1)
      else $error("lane %0d commits out of sequence", i);
  end

  // Rename may run 63 ops ahead of the oldest one
  assert property (@(posedge clk) disable iff (rst)
    maxSqN == sqN_t'(curSqN + RobLength - 1))
    else $error("maxSqN does not track curSqN");

endmodule

bind reorderBuffer reorderBufferProps props (
  .clk(clk), .rst(rst), .comValid(comValid), .comSqN(comSqN),
  .trapValid(trapValid), .curSqN(curSqN), .maxSqN(maxSqN)
);

// File: tbReorderBuffer.sv
`timescale 1ns/1ns

module tbReorderBuffer;
  import robPkg::*;

  // One op as the model tracks it
  typedef struct {
    sqN_t sqN;
    logic [KindBits-1:0] kind;
    robFlags_t flags;
    robDest_u dest;
    tag_t tag;
  } refOp_t;

  logic clk = 1'b0;
  logic rst;
  logic enqValid [DecWidth];
  sqN_t enqSqN [DecWidth];
  tag_t enqTag [DecWidth];
  robDest_u enqDest [DecWidth];
  logic [KindBits-1:0] enqKind [DecWidth];
  logic compValid [NumCompPorts];
  sqN_t compSqN [NumCompPorts];
  robFlags_t compFlags [NumCompPorts];
  logic brTaken;
  sqN_t brSqN;
  logic comValid [DecWidth];
  sqN_t comSqN [DecWidth];
  regNm_t comRd [DecWidth];
  tag_t comTag [DecWidth];
  logic trapValid;
  sqN_t trapSqN;
  tag_t trapTag;
  robDest_u trapDest;
  robFlags_t trapFlags;
  sqN_t curSqN;
  sqN_t maxSqN;

  refOp_t refQ [$];
  refOp_t expOp [DecWidth];
  refOp_t expTrapOp;
  logic expValid [DecWidth];
  logic expTrap;
  sqN_t refBase;
  sqN_t nextSqN = '0;
  sqN_t pending [$];
  logic windowFull;
  logic [31:0] lfsr = 32'hd8835eb0;
  int errors = 0;
  int checks = 0;
  int testsRun = 0;
  int testErrs = 0;
  int trapSeen = 0;
  int cycles = 0;

  reorderBuffer UUT (.*);

  always #10 clk = ~clk;

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // True when a lies after b within half the sequence space
  function automatic logic younger(input sqN_t a, input sqN_t b);
    sqN_t d;
    d = a - b;
    return d != '0 && !d[RobIdLen];
  endfunction

  // Commit group from the model state before the edge
  function automatic int refCommit(input logic stopped);
    int n;
    logic open;
    n = 0;
    open = !stopped;
    expTrap = 1'b0;
    for (int i = 0; i < DecWidth; i++) begin
      expValid[i] = 1'b0;
      if (open && i < refQ.size() && refQ[i].flags != NotExecuted) begin
        expValid[i] = 1'b1;
        expOp[i] = refQ[i];
        n++;
        if (refQ[i].flags == Trap || refQ[i].flags == Exception) begin
          expTrap = 1'b1;
          expTrapOp = refQ[i];
          open = 1'b0;
        end
      end else begin
        open = 1'b0;
      end
    end
    return n;
  endfunction

  task automatic checkValue(input string name, input int lane,
                            input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s[%0d] got %0h expected %0h", $time, name, lane, got, exp);
    end
  endtask

  task automatic expectTrue(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic checkOutputs();
    logic trapLane;
    checkValue("curSqN", 0, curSqN, refBase);
    // Window holds RobLength ops starting at the oldest live one
    checkValue("maxSqN", 0, maxSqN, sqN_t'(refBase + RobLength - 1));
    checkValue("trapValid", 0, trapValid, expTrap);
    if (trapValid === 1'b1) trapSeen++;
    for (int i = 0; i < DecWidth; i++) begin
      checkValue("comValid", i, comValid[i], expValid[i]);
      if (expValid[i]) begin
        trapLane = expOp[i].flags == Trap || expOp[i].flags == Exception;
        checkValue("comSqN", i, comSqN[i], expOp[i].sqN);
        checkValue("comRd", i, comRd[i], trapLane ? 0 : expOp[i].dest.rd);
        checkValue("comTag", i, comTag[i], trapLane ? TagZero : expOp[i].tag);
      end
    end
    if (expTrap) begin
      checkValue("trapSqN", 0, trapSqN, expTrapOp.sqN);
      checkValue("trapTag", 0, trapTag, expTrapOp.tag);
      checkValue("trapDest", 0, trapDest, expTrapOp.dest);
      checkValue("trapFlags", 0, trapFlags, expTrapOp.flags);
    end
  endtask

  // Check the outputs registered at the last edge and step the model
  always @(posedge clk) begin
    int n;
    refOp_t op;
    if (rst) begin
      refQ.delete();
      refBase = '0;
      expTrap = 1'b0;
      for (int i = 0; i < DecWidth; i++) expValid[i] = 1'b0;
    end else begin
      checkOutputs();
      // Last cycle's trap blocks this one
      n = refCommit(expTrap);
      refBase = refBase + sqN_t'(n);
      repeat (n) refQ.delete(0);
      if (brTaken) begin
        while (refQ.size() > 0 && younger(refQ[refQ.size() - 1].sqN, brSqN)) begin
          refQ.delete(refQ.size() - 1);
        end
      end else begin
        for (int i = 0; i < DecWidth; i++) begin
          if (enqValid[i]) begin
            op.sqN = enqSqN[i];
            op.kind = enqKind[i];
            op.dest = enqDest[i];
            op.tag = enqTag[i];
            if (op.kind == KindTrap) op.flags = Trap;
            else if (op.kind == KindRename) op.flags = None;
            else op.flags = NotExecuted;
            refQ.push_back(op);
          end
        end
      end
      // Ops already gone from the queue ignore their completions
      for (int p = 0; p < NumCompPorts; p++) begin
        for (int k = 0; k < refQ.size(); k++) begin
          if (compValid[p] && refQ[k].sqN == compSqN[p]) refQ[k].flags = compFlags[p];
        end
      end
    end
  end

  // Five times the expected length of all tests
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("Timeout after %0d cycles, ops still in flight", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic idleInputs();
    for (int i = 0; i < DecWidth; i++) begin
      enqValid[i] = 1'b0;
      enqSqN[i] = '0;
      enqTag[i] = '0;
      enqDest[i] = '0;
      enqKind[i] = KindExecute;
    end
    for (int p = 0; p < NumCompPorts; p++) begin
      compValid[p] = 1'b0;
      compSqN[p] = '0;
      compFlags[p] = None;
    end
    brTaken = 1'b0;
    brSqN = '0;
  endtask

  task automatic putOp(input int lane, input logic [KindBits-1:0] kind);
    enqValid[lane] = 1'b1;
    enqSqN[lane] = nextSqN;
    enqTag[lane] = tag_t'(randBits(7));
    enqDest[lane].rd = regNm_t'(randBits(5));
    enqKind[lane] = kind;
    if (kind == KindExecute) pending.push_back(nextSqN);
    nextSqN = nextSqN + 1'b1;
  endtask

  // Renames nOps ops and completes the execute ops in random order
  task automatic runOps(input int nOps, input logic [KindBits-1:0] kind,
                        input int trapAt, input logic holdComp);
    int issued;
    int lane;
    int cnt;
    int idx;
    logic hasExc;
    sqN_t excSqN;
    issued = 0;
    hasExc = 1'b0;
    excSqN = '0;
    windowFull = 1'b0;
    while (issued < nOps || pending.size() > 0) begin
      @(negedge clk);
      idleInputs();
      for (int p = 0; p < NumCompPorts; p++) begin
        if ((!holdComp || windowFull) && pending.size() > 0 && randBits(1) != 0) begin
          idx = int'(randBits(6)) % pending.size();
          compValid[p] = 1'b1;
          compSqN[p] = pending[idx];
          if (hasExc && pending[idx] == excSqN) compFlags[p] = Exception;
          else compFlags[p] = randBits(1) != 0 ? Branch : None;
          pending.delete(idx);
        end
      end
      lane = 0;
      cnt = int'(randBits(2)) + 1;
      // Rename holds once the next op would pass maxSqN
      while (lane < cnt && issued < nOps && !younger(nextSqN, maxSqN)) begin
        if (issued == trapAt && kind == KindExecute) begin
          hasExc = 1'b1;
          excSqN = nextSqN;
        end
        putOp(lane, (issued == trapAt && kind == KindRename) ? KindTrap : kind);
        lane++;
        issued++;
      end
      if (younger(nextSqN, maxSqN)) windowFull = 1'b1;
    end
    @(negedge clk);
    idleInputs();
    while (curSqN != nextSqN) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic endTest(input string name);
    testsRun++;
    $display("%s finished with %0d errors", name, errors - testErrs);
    testErrs = errors;
  endtask

  initial begin
    int trapBefore;
    sqN_t brBase;
    idleInputs();
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    runOps(40, KindRename, -1, 1'b0);
    endTest("rename-complete ops");
    runOps(40, KindExecute, -1, 1'b0);
    endTest("out-of-order completion");

    trapBefore = trapSeen;
    runOps(12, KindRename, 5, 1'b0);
    expectTrue(trapSeen == trapBefore + 1, "decode trap did not give one trap record");
    endTest("decode trap");

    trapBefore = trapSeen;
    runOps(16, KindExecute, 7, 1'b0);
    expectTrue(trapSeen == trapBefore + 1, "exception did not give one trap record");
    endTest("execution exception");

    // Branch on the third of eight ops with a wrong-path rename and completion
    brBase = nextSqN;
    for (int c = 0; c < 2; c++) begin
      @(negedge clk);
      idleInputs();
      for (int i = 0; i < DecWidth; i++) putOp(i, KindExecute);
    end
    @(negedge clk);
    idleInputs();
    brTaken = 1'b1;
    brSqN = brBase + 7'd2;
    compValid[0] = 1'b1;
    compSqN[0] = brBase + 7'd2;
    compFlags[0] = Branch;
    compValid[1] = 1'b1;
    compSqN[1] = brBase + 7'd5;
    compFlags[1] = None;
    putOp(0, KindRename);
    putOp(1, KindRename);
    pending.delete();
    nextSqN = brBase + 7'd3;
    @(negedge clk);
    idleInputs();
    compValid[0] = 1'b1;
    compSqN[0] = brBase;
    compValid[1] = 1'b1;
    compSqN[1] = brBase + 7'd1;
    runOps(8, KindRename, -1, 1'b0);
    endTest("taken branch");

    runOps(100, KindExecute, -1, 1'b1);
    expectTrue(windowFull, "window never filled up to maxSqN");
    endTest("full window");

    $display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: reorderBuffer.f
robPkg.sv
robEntryBanks.sv
robFlagTable.sv
robWindow.sv
robCommit.sv
reorderBuffer.sv
reorderBuffer_props.sv
tbReorderBuffer.sv

// File: Makefile
BIN = obj_dir/VtbReorderBuffer

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): reorderBuffer.f $(wildcard *.sv)
	verilator --binary --assert -Wno-fatal --top-module tbReorderBuffer -f reorderBuffer.f

run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
